// ==== tb/pi_bridge_trace.txt ====
// op (0 write, 1 read, 2 other command, f end), 17-bit address, data, expected
// expected is the bus data for writes, the byte returned for reads, unused otherwise
0 00123 a5 a5
1 00123 00 a5
1 10123 00 a5
1 00523 00 a5
0 1fe01 3c 3c
1 00201 00 3c
1 0fe01 00 3c
2 00123 77 00
1 00123 00 a5
0 003ff 81 81
1 103ff 00 81
2 003ff 00 00
1 003ff 00 81
0 00000 5e 5e
1 0fc00 00 5e
1 1fc00 00 5e
f 00000 00 00

// ==== list.f ====
logic/pi_bridge_pkg.sv
logic/spi_byte_shifter.sv
logic/spi_frame_buffer.sv
logic/pi_cmd_decoder.sv
logic/bus_target_ram.sv
logic/pi_bridge_top.sv
tb/pi_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the bridge testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module pi_bridge_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vpi_bridge_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

// ==== tb/pi_bridge_tb.sv ====
/*
 * Testbench for the SPI to bus bridge. Plays SPI frames from a trace file
 * and checks the bus request, the done and pending levels and read data.
 */
`timescale 1ns/10ps
`default_nettype none

module pi_bridge_tb;
    import pi_bridge_pkg::*;

    localparam int   max_lines   = 32;
    localparam int   drive_delay = 2;       // ns after the rising clock edge.
    localparam cmd_t bad_cmd     = 6'h2a;   // any command other than the access one.

    logic        state_clk;
    logic        pi_pending_in;
    logic        spi_sclk;
    logic        spi_cs_n;
    logic        spi_rx;
    logic        spi_tx;
    logic        pi_pending_out;
    logic        pi_done_out;
    bus_req_t    bus_req;

    logic [16:0] trace_words [0:4*max_lines-1];   // four columns per transaction.
    int          line_count;
    int          cycle_count;
    int          cycle_limit;
    int          check_count;
    int          error_count;
    int unsigned seed_val;

    pi_bridge_top pi_bridge_top_inst (
        .state_clk      (state_clk),
        .pi_pending_in  (pi_pending_in),
        .spi_sclk       (spi_sclk),
        .spi_cs_n       (spi_cs_n),
        .spi_rx         (spi_rx),
        .spi_tx         (spi_tx),
        .pi_pending_out (pi_pending_out),
        .pi_done_out    (pi_done_out),
        .bus_req        (bus_req)
    );

    initial begin
        state_clk = 1'b0;
        forever #50 state_clk = ~state_clk;
    end

    //////////////////////////////////////////////////
    // helpers.
    //////////////////////////////////////////////////
    task automatic tick(input int n);
        repeat (n) @(posedge state_clk);
        #drive_delay;
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count = check_count + 1;
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // one mode 0 byte, four clock cycles per sclk half period.
    task automatic shift_byte(input byte_t out_val, output byte_t in_val);
        int i;
        for (i = 7; i >= 0; i = i - 1) begin
            spi_rx = out_val[i];
            tick(4);
            in_val[i] = spi_tx;   // host samples just before the rising edge.
            spi_sclk = 1'b1;
            tick(4);
            spi_sclk = 1'b0;
        end
    endtask

    task automatic wait_done();
        while (pi_done_out !== 1'b1) begin
            tick(1);
        end
    endtask

    task automatic run_transaction(input logic [3:0] op, input bus_addr_t addr,
                                   input byte_t data, input byte_t expected);
        cmd_t  cmd;
        byte_t payload;
        byte_t unused_rx;
        byte_t read_back;
        cmd     = (op == 4'h2) ? bad_cmd : cmd_t'(cmd_access);
        payload = (op == 4'h1) ? byte_t'($urandom) : data;

        pi_pending_in = 1'b0;   // idle period between transactions.
        tick(8);
        pi_pending_in = 1'b1;
        tick(2 + int'($urandom % 8));
        check_value(32'(pi_pending_out), 32'(0), "pending after reset");
        check_value(32'(pi_done_out), 32'(0), "done after reset");

        spi_cs_n = 1'b0;
        tick(4);
        shift_byte({(op == 4'h1), addr[16], cmd}, unused_rx);
        shift_byte(addr[15:8], unused_rx);   // high address byte first.
        shift_byte(addr[7:0], unused_rx);
        shift_byte(payload, unused_rx);
        if (op == 4'h2) begin
            // an other command ends at byte 0, long before the frame does.
            check_value(32'(pi_done_out), 32'(1), "done after other command");
        end
        wait_done();

        case (op)
            4'h0: begin
                check_value(32'(pi_pending_out), 32'(1), "pending after write");
                check_value(32'(bus_req.rw_b), 32'(0), "write rw_b");
                check_value(32'(bus_req.addr), 32'(addr), "write address");
                check_value(32'(bus_req.data), 32'(expected), "write data");
            end
            4'h1: begin
                shift_byte(8'h00, read_back);
                check_value(32'(pi_pending_out), 32'(1), "pending after read");
                check_value(32'(bus_req.rw_b), 32'(1), "read rw_b");
                check_value(32'(bus_req.addr), 32'(addr), "read address");
                check_value(32'(read_back), 32'(expected), "read data on spi_tx");
            end
            default: begin
                check_value(32'(pi_pending_out), 32'(0), "pending after other command");
            end
        endcase

        tick(4);
        spi_cs_n = 1'b1;
        tick(4);
    endtask

    //////////////////////////////////////////////////
    // timeout and main sequence.
    //////////////////////////////////////////////////
    initial begin : watchdog
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge state_clk);
            cycle_count = cycle_count + 1;
        end
        $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
        $display("Checks failed");
        $finish;
    end

    initial begin
        int n;
        pi_pending_in = 1'b0;
        spi_sclk      = 1'b0;
        spi_cs_n      = 1'b1;
        spi_rx        = 1'b0;
        check_count   = 0;
        error_count   = 0;
        cycle_count   = 0;
        cycle_limit   = 0;
        line_count    = 0;
        seed_val      = $urandom(32'h378c);

        $readmemh("tb/pi_bridge_trace.txt", trace_words);
        while ((line_count < max_lines) && (trace_words[4*line_count] !== 17'hf)) begin
            line_count = line_count + 1;
        end
        if (line_count == 0) begin
            error_count = error_count + 1;
            $display("the trace file holds no transactions");
        end
        cycle_limit = 2000 * ((line_count > 0) ? line_count : 1);

        for (n = 0; n < line_count; n = n + 1) begin
            run_transaction(trace_words[4*n][3:0], trace_words[4*n+1],
                            trace_words[4*n+2][7:0], trace_words[4*n+3][7:0]);
        end

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/pi_bridge_top.sv ====
/*
 * SPI to bus bridge top level. Connects the shifter, frame buffer,
 * command decoder and target RAM.
 */
`timescale 1ns/10ps
`default_nettype none

module pi_bridge_top (
    input  wire logic               state_clk,
    input  wire logic               pi_pending_in,   // also the async reset.
    input  wire logic               spi_sclk,
    input  wire logic               spi_cs_n,
    input  wire logic               spi_rx,
    output logic                    spi_tx,
    output logic                    pi_pending_out,
    output logic                    pi_done_out,
    output pi_bridge_pkg::bus_req_t bus_req
);
    import pi_bridge_pkg::*;

    byte_t                   rx_byte;
    logic                    rx_strobe;
    logic                    frame_start;
    byte_t [frame_bytes-1:0] frame;
    logic                    valid;
    frame_len_t              length;
    logic                    req_pending;
    logic                    req_done;
    byte_t                   rd_data;

    spi_byte_shifter spi_byte_shifter_inst (
        .state_clk     (state_clk),
        .pi_pending_in (pi_pending_in),
        .spi_sclk      (spi_sclk),
        .spi_cs_n      (spi_cs_n),
        .spi_rx        (spi_rx),
        .spi_tx        (spi_tx),
        .tx_byte       (rd_data),   // read data goes back to the host.
        .rx_byte       (rx_byte),
        .rx_strobe     (rx_strobe),
        .frame_start   (frame_start)
    );

    spi_frame_buffer spi_frame_buffer_inst (
        .state_clk     (state_clk),
        .pi_pending_in (pi_pending_in),
        .rx_byte       (rx_byte),
        .rx_strobe     (rx_strobe),
        .frame_start   (frame_start),
        .length        (length),
        .frame         (frame),
        .valid         (valid)
    );

    pi_cmd_decoder pi_cmd_decoder_inst (
        .state_clk      (state_clk),
        .pi_pending_in  (pi_pending_in),
        .frame          (frame),
        .valid          (valid),
        .length         (length),
        .req            (bus_req),
        .req_pending    (req_pending),
        .req_done       (req_done),
        .pi_pending_out (pi_pending_out),
        .pi_done_out    (pi_done_out)
    );

    bus_target_ram bus_target_ram_inst (
        .state_clk     (state_clk),
        .pi_pending_in (pi_pending_in),
        .req           (bus_req),
        .req_pending   (req_pending),
        .req_done      (req_done),
        .rd_data       (rd_data)
    );

endmodule

`default_nettype wire

// ==== logic/bus_target_ram.sv ====
/*
 * Byte-wide bus target RAM. Answers one request after a fixed wait with a
 * done level and, for reads, the data at the low address bits.
 */
`timescale 1ns/10ps
`default_nettype none

module bus_target_ram (
    input  wire logic                    state_clk,
    input  wire logic                    pi_pending_in,
    input  wire pi_bridge_pkg::bus_req_t req,
    input  wire logic                    req_pending,
    output logic                         req_done,
    output pi_bridge_pkg::byte_t         rd_data
);
    import pi_bridge_pkg::*;

    byte_t mem [2**ram_addr_bits];   // contents survive reset.

    logic [$clog2(access_wait_cycles+1)-1:0] wait_cnt;
    logic [ram_addr_bits-1:0]                ram_addr;
    logic                                    access_fire;

    assign ram_addr    = req.addr[ram_addr_bits-1:0];   // upper bits alias.
    assign access_fire = req_pending && !req_done
                      && (wait_cnt == $bits(wait_cnt)'(access_wait_cycles - 1));

    //////////////////////////////////////////////////
    // access timing and read capture.
    //////////////////////////////////////////////////
    always_ff @(posedge state_clk or negedge pi_pending_in) begin
        if (!pi_pending_in) begin
            wait_cnt <= '0;
            req_done <= 1'b0;
            rd_data  <= '0;
        end else if (access_fire) begin
            req_done <= 1'b1;
            if (req.rw_b) begin
                rd_data <= mem[ram_addr];
            end
        end else if (req_pending && !req_done) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge state_clk) begin
        if (access_fire && !req.rw_b) begin
            mem[ram_addr] <= req.data;
        end
    end

    // the decoder holds the request steady for the whole access.
    assert property (@(posedge state_clk) disable iff (!pi_pending_in)
        req_pending |=> $stable(req));

endmodule

`default_nettype wire

// ==== logic/pi_cmd_decoder.sv ====
/*
 * Command decoder FSM. Walks through the frame, builds the bus request for
 * the access command and reports pending and done to the host.
 */
`timescale 1ns/10ps
`default_nettype none

module pi_cmd_decoder (
    input  wire logic                      state_clk,
    input  wire logic                      pi_pending_in,
    input  wire pi_bridge_pkg::byte_t [pi_bridge_pkg::frame_bytes-1:0] frame,
    input  wire logic                      valid,
    output pi_bridge_pkg::frame_len_t      length,
    output pi_bridge_pkg::bus_req_t        req,
    output logic                           req_pending,
    input  wire logic                      req_done,
    output logic                           pi_pending_out,
    output logic                           pi_done_out
);
    import pi_bridge_pkg::*;

    decoder_state_t state;
    decoder_state_t next_state;

    // fields of frame byte 0.
    wire logic rw_b_in = frame[0][7];
    wire logic a16_in  = frame[0][6];
    wire cmd_t cmd_in  = frame[0][5:0];

    assign pi_pending_out = req_pending;

    //////////////////////////////////////////////////
    // next state.
    //////////////////////////////////////////////////
    always_comb begin
        next_state = state;
        unique case (state)
            idle: begin
                next_state = read_cmd;   // reset has just been released.
            end
            read_cmd: begin
                if (valid && (length == frame_len_t'(1))) begin
                    if (cmd_in == cmd_t'(cmd_access)) begin
                        next_state = writing;
                    end else begin
                        next_state = done;   // unknown command, no access.
                    end
                end
            end
            writing: begin
                if (valid && (length == frame_len_t'(frame_bytes))) begin
                    next_state = completing;
                end
            end
            completing: begin
                if (req_done) begin
                    next_state = done;
                end
            end
            done: begin
                next_state = done;
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // state register and outputs set on entry.
    //////////////////////////////////////////////////
    always_ff @(posedge state_clk or negedge pi_pending_in) begin
        if (!pi_pending_in) begin
            state       <= idle;
            length      <= '0;
            req         <= '0;
            req_pending <= 1'b0;
            pi_done_out <= 1'b0;
        end else begin
            state <= next_state;
            if (next_state != state) begin
                unique case (next_state)
                    idle:     length <= '0;
                    read_cmd: length <= frame_len_t'(1);
                    writing:  length <= frame_len_t'(frame_bytes);
                    completing: begin
                        req.rw_b    <= rw_b_in;
                        req.addr    <= {a16_in, frame[1], frame[2]};   // high byte first.
                        req.data    <= frame[3];
                        req_pending <= 1'b1;
                    end
                    done:     pi_done_out <= 1'b1;
                    default:  length <= '0;
                endcase
            end
        end
    end

    // done only follows a finished access, never one still in flight.
    assert property (@(posedge state_clk) disable iff (!pi_pending_in)
        $rose(pi_done_out) |-> !(req_pending && !req_done));

endmodule

`default_nettype wire

// ==== logic/spi_frame_buffer.sv ====
/*
 * Frame buffer for received SPI bytes. Holds up to four bytes and reports
 * when the length requested by the decoder has arrived.
 */
`timescale 1ns/10ps
`default_nettype none

module spi_frame_buffer (
    input  wire logic                         state_clk,
    input  wire logic                         pi_pending_in,
    input  wire pi_bridge_pkg::byte_t         rx_byte,
    input  wire logic                         rx_strobe,
    input  wire logic                         frame_start,
    input  wire pi_bridge_pkg::frame_len_t    length,
    output pi_bridge_pkg::byte_t [pi_bridge_pkg::frame_bytes-1:0] frame,
    output logic                              valid
);
    import pi_bridge_pkg::*;

    frame_len_t                  count;     // bytes stored since chip select fell.
    byte_t [frame_bytes-1:0]     frame_q;

    assign frame = frame_q;
    assign valid = (length != '0) && (count >= length);

    always_ff @(posedge state_clk or negedge pi_pending_in) begin
        if (!pi_pending_in) begin
            count <= '0;
        end else if (frame_start) begin
            count <= '0;
        end else if (rx_strobe && (count < frame_len_t'(frame_bytes))) begin
            count <= count + frame_len_t'(1);
        end
    end

    // payload storage. Bytes past the frame length are dropped.
    always_ff @(posedge state_clk) begin
        if (rx_strobe && !frame_start && (count < frame_len_t'(frame_bytes))) begin
            frame_q[count[1:0]] <= rx_byte;
        end
    end

    assert property (@(posedge state_clk) disable iff (!pi_pending_in)
        count <= frame_len_t'(frame_bytes));

endmodule

`default_nettype wire

// ==== logic/spi_byte_shifter.sv ====
/*
 * SPI mode 0 byte shifter running on the system clock. Synchronizes the pins,
 * collects received bytes with a strobe and shifts the transmit byte out.
 */
`timescale 1ns/10ps
`default_nettype none

module spi_byte_shifter (
    input  wire logic                 state_clk,
    input  wire logic                 pi_pending_in,
    input  wire logic                 spi_sclk,
    input  wire logic                 spi_cs_n,
    input  wire logic                 spi_rx,
    output logic                      spi_tx,
    input  wire pi_bridge_pkg::byte_t tx_byte,
    output pi_bridge_pkg::byte_t      rx_byte,
    output logic                      rx_strobe,
    output logic                      frame_start
);
    import pi_bridge_pkg::*;

    logic [sync_stages-1:0] sclk_sync;
    logic [sync_stages-1:0] cs_sync;
    logic [sync_stages-1:0] rx_sync;
    logic                   sclk_prev;
    logic                   cs_prev;
    logic [2:0]             bit_cnt;
    byte_t                  rx_shift;
    byte_t                  tx_shift;

    wire logic sclk_q    = sclk_sync[sync_stages-1];
    wire logic cs_q      = cs_sync[sync_stages-1];
    wire logic sclk_rise = sclk_q & ~sclk_prev;
    wire logic sclk_fall = ~sclk_q & sclk_prev;

    assign frame_start = cs_prev & ~cs_q;   // chip select just went active.
    assign spi_tx      = tx_shift[7];

    //////////////////////////////////////////////////
    // pin synchronizers and edge history.
    //////////////////////////////////////////////////
    always_ff @(posedge state_clk or negedge pi_pending_in) begin
        if (!pi_pending_in) begin
            sclk_sync <= '0;
            cs_sync   <= '1;   // chip select idles high.
            rx_sync   <= '0;
            sclk_prev <= 1'b0;
            cs_prev   <= 1'b1;
        end else begin
            sclk_sync <= {sclk_sync[sync_stages-2:0], spi_sclk};
            cs_sync   <= {cs_sync[sync_stages-2:0], spi_cs_n};
            rx_sync   <= {rx_sync[sync_stages-2:0], spi_rx};
            sclk_prev <= sclk_q;
            cs_prev   <= cs_q;
        end
    end

    //////////////////////////////////////////////////
    // receive and transmit shifting.
    //////////////////////////////////////////////////
    always_ff @(posedge state_clk or negedge pi_pending_in) begin
        if (!pi_pending_in) begin
            bit_cnt   <= '0;
            rx_shift  <= '0;
            rx_byte   <= '0;
            rx_strobe <= 1'b0;
            tx_shift  <= '0;
        end else begin
            rx_strobe <= 1'b0;
            if (cs_q) begin
                bit_cnt <= '0;   // deselected, so the next byte starts fresh.
            end else if (sclk_rise) begin
                rx_shift <= {rx_shift[6:0], rx_sync[sync_stages-1]};
                bit_cnt  <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    rx_byte   <= {rx_shift[6:0], rx_sync[sync_stages-1]};
                    rx_strobe <= 1'b1;
                end
            end

            // At a byte boundary the next byte is kept loaded, so its bit 7
            // is on the pin before the first rising edge of that byte.
            if (bit_cnt == 3'd0) begin
                tx_shift <= tx_byte;
            end else if (sclk_fall) begin
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

    // one strobe per byte, and bytes are at least eight edges apart.
    assert property (@(posedge state_clk) disable iff (!pi_pending_in)
        rx_strobe |=> !rx_strobe);

endmodule

`default_nettype wire

// ==== logic/pi_bridge_pkg.sv ====
/*
 * SPI bridge shared definitions: widths, bus request, decoder states and
 * the constants for frame length, RAM size and access timing.
 */
`default_nettype none

package pi_bridge_pkg;

    //////////////////////////////////////////////////
    // widths that carry a meaning.
    //////////////////////////////////////////////////
    typedef logic [7:0]  byte_t;       // one SPI or bus data byte.
    typedef logic [16:0] bus_addr_t;   // a16 followed by address bytes 1 and 2.
    typedef logic [5:0]  cmd_t;        // command field of frame byte 0.
    typedef logic [2:0]  frame_len_t;  // bytes the decoder wants buffered, 0 to 4.

    // one bus access as seen by the target.
    typedef struct packed {
        logic      rw_b;   // 1 means read.
        bus_addr_t addr;
        byte_t     data;
    } bus_req_t;

    typedef enum logic [2:0] {
        idle,
        read_cmd,
        writing,
        completing,
        done
    } decoder_state_t;

    //////////////////////////////////////////////////
    // constants.
    //////////////////////////////////////////////////
    localparam int cmd_access         = 0;   // perform one bus access.
    localparam int frame_bytes        = 4;
    localparam int ram_addr_bits      = 10;
    localparam int access_wait_cycles = 2;   // request rise to done rise.
    localparam int sync_stages        = 2;

endpackage

`default_nettype wire
